// ==== design/tdp_ram_pkg.sv ====
package tdp_ram_pkg;

    // **************************************************
    // memory geometry.
    // **************************************************

    // bits per stored word.
    localparam int ram_width = 32;

    // number of words in the array.
    localparam int ram_depth = 32;

    // enough address bits to reach every word.
    localparam int addr_width = $clog2(ram_depth);

    // **************************************************
    // shared types.
    // **************************************************

    // one data word, as written, stored and read back.
    typedef logic [ram_width-1:0] word_t;

    // word address, the same on both ports.
    typedef logic [addr_width-1:0] addr_t;

endpackage

// ==== design/tdp_ram_array.sv ====
`timescale 1ns/1ps

module tdp_ram_array (
    input  logic                clk,

    // port a request.
    input  logic                we_a,
    input  tdp_ram_pkg::addr_t  addr_a,
    input  tdp_ram_pkg::word_t  din_a,

    // port b request.
    input  logic                we_b,
    input  tdp_ram_pkg::addr_t  addr_b,
    input  tdp_ram_pkg::word_t  din_b,

    // registered read data, one per port.
    output tdp_ram_pkg::word_t  ram_dout_a,
    output tdp_ram_pkg::word_t  ram_dout_b
);

    import tdp_ram_pkg::*;

    // **************************************************
    // storage.
    // **************************************************

    word_t mem [ram_depth];

    // **************************************************
    // write path.
    // **************************************************

    // port b is applied before port a in the same block, so on a
    // same-address conflict the later update from port a is the one kept.
    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= din_b;
        end
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
    end

    // **************************************************
    // read path.
    // **************************************************

    // read-first on both ports.
    // the sample is taken before this edge's writes land in the array.
    always_ff @(posedge clk) begin
        ram_dout_a <= mem[addr_a];
    end

    always_ff @(posedge clk) begin
        ram_dout_b <= mem[addr_b];
    end

endmodule

// ==== design/collision_bypass.sv ====
`timescale 1ns/1ps

module collision_bypass (
    input  logic                clk,
    input  logic                rst,

    // port a request, same cycle as the array sees it.
    input  logic                we_a,
    input  tdp_ram_pkg::addr_t  addr_a,
    input  tdp_ram_pkg::word_t  din_a,

    // port b request.
    input  logic                we_b,
    input  tdp_ram_pkg::addr_t  addr_b,
    input  tdp_ram_pkg::word_t  din_b,

    // read-first words from the array, one cycle after the request.
    input  tdp_ram_pkg::word_t  ram_dout_a,
    input  tdp_ram_pkg::word_t  ram_dout_b,

    // resolved read data.
    output tdp_ram_pkg::word_t  dout_a,
    output tdp_ram_pkg::word_t  dout_b
);

    import tdp_ram_pkg::*;

    // **************************************************
    // request history.
    // **************************************************

    logic  we_a_q;
    addr_t addr_a_q;
    word_t din_a_q;

    logic  we_b_q;
    addr_t addr_b_q;
    word_t din_b_q;

    // one-cycle copy of each port's request, lined up with the array output.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we_a_q   <= 1'b0;
            addr_a_q <= '0;
            din_a_q  <= '0;
            we_b_q   <= 1'b0;
            addr_b_q <= '0;
            din_b_q  <= '0;
        end else begin
            we_a_q   <= we_a;
            addr_a_q <= addr_a;
            din_a_q  <= din_a;
            we_b_q   <= we_b;
            addr_b_q <= addr_b;
            din_b_q  <= din_b;
        end
    end

    // **************************************************
    // collision decode.
    // **************************************************

    logic addr_match;
    logic fwd_a_both;
    logic fwd_b_both;
    logic own_a;
    logic own_b;

    assign addr_match = (addr_a_q == addr_b_q);

    // a single writer on a shared address feeds both ports.
    assign fwd_a_both = addr_match && we_a_q && !we_b_q;
    assign fwd_b_both = addr_match && !we_a_q && we_b_q;

    // separate addresses, a writer sees its own data.
    assign own_a = !addr_match && we_a_q;
    assign own_b = !addr_match && we_b_q;

    // **************************************************
    // output select.
    // **************************************************

    // two writers on one address fall through to the array,
    // which still shows the old contents.
    always_comb begin
        if (fwd_a_both || own_a) begin
            dout_a = din_a_q;
        end else if (fwd_b_both) begin
            dout_a = din_b_q;
        end else begin
            dout_a = ram_dout_a;
        end
    end

    always_comb begin
        if (fwd_b_both || own_b) begin
            dout_b = din_b_q;
        end else if (fwd_a_both) begin
            dout_b = din_a_q;
        end else begin
            dout_b = ram_dout_b;
        end
    end

endmodule

// ==== design/tdp_ram.sv ====
`timescale 1ns/1ps

module tdp_ram (
    input  logic                clk,
    input  logic                rst,

    // port a.
    input  logic                we_a,
    input  tdp_ram_pkg::addr_t  addr_a,
    input  tdp_ram_pkg::word_t  din_a,
    output tdp_ram_pkg::word_t  dout_a,

    // port b.
    input  logic                we_b,
    input  tdp_ram_pkg::addr_t  addr_b,
    input  tdp_ram_pkg::word_t  din_b,
    output tdp_ram_pkg::word_t  dout_b
);

    import tdp_ram_pkg::*;

    // raw read-first words, before collision handling.
    word_t ram_dout_a;
    word_t ram_dout_b;

    // **************************************************
    // storage array.
    // **************************************************

    tdp_ram_array u_array (
        .clk        (clk),
        .we_a       (we_a),
        .addr_a     (addr_a),
        .din_a      (din_a),
        .we_b       (we_b),
        .addr_b     (addr_b),
        .din_b      (din_b),
        .ram_dout_a (ram_dout_a),
        .ram_dout_b (ram_dout_b)
    );

    // **************************************************
    // collision bypass.
    // **************************************************

    // sees the same requests as the array and fixes up what each port shows.
    collision_bypass u_bypass (
        .clk        (clk),
        .rst        (rst),
        .we_a       (we_a),
        .addr_a     (addr_a),
        .din_a      (din_a),
        .we_b       (we_b),
        .addr_b     (addr_b),
        .din_b      (din_b),
        .ram_dout_a (ram_dout_a),
        .ram_dout_b (ram_dout_b),
        .dout_a     (dout_a),
        .dout_b     (dout_b)
    );

endmodule

// ==== tests/tb_tdp_ram.sv ====
`timescale 1ns/1ps

module tb_tdp_ram;

    import tdp_ram_pkg::*;

    localparam int clk_half = 10;
    localparam int stim_delay = 1;
    localparam int reset_cycles = 8;
    // the tests run for a few hundred cycles.
    localparam int timeout_cycles = 2000;
    localparam logic [31:0] lfsr_seed = 32'd77;

    logic  clk;
    logic  rst;
    logic  we_a;
    addr_t addr_a;
    word_t din_a;
    word_t dout_a;
    logic  we_b;
    addr_t addr_b;
    word_t din_b;
    word_t dout_b;

    logic [31:0] lfsr_state;
    word_t       model_mem [ram_depth];
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    tdp_ram UUT (
        .clk    (clk),
        .rst    (rst),
        .we_a   (we_a),
        .addr_a (addr_a),
        .din_a  (din_a),
        .dout_a (dout_a),
        .we_b   (we_b),
        .addr_b (addr_b),
        .din_b  (din_b),
        .dout_b (dout_b)
    );

    always #(clk_half) clk = ~clk;

    // **************************************************
    // stimulus data.
    // **************************************************

    // right-shifting galois form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken.
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[ram_width-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // **************************************************
    // checking.
    // **************************************************

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, fail_count - fails_before);
        end
    endtask

    // one request on both ports, then the outputs one edge later.
    // called and returns at stim_delay after a rising edge.
    task automatic run_cycle(input logic wa, input addr_t aa, input word_t da,
                             input logic wb, input addr_t ab, input word_t db);
        word_t old_a;
        word_t old_b;
        word_t exp_a;
        word_t exp_b;
        we_a   = wa;
        addr_a = aa;
        din_a  = da;
        we_b   = wb;
        addr_b = ab;
        din_b  = db;
        old_a  = model_mem[aa];
        old_b  = model_mem[ab];
        if (aa == ab) begin
            if (wa && !wb) begin
                exp_a = da;
                exp_b = da;
            end else if (wb && !wa) begin
                exp_a = db;
                exp_b = db;
            end else begin
                // two reads, or two writers where both see the old word.
                exp_a = old_a;
                exp_b = old_b;
            end
        end else begin
            exp_a = wa ? da : old_a;
            exp_b = wb ? db : old_b;
        end
        // port a lands last on a shared address.
        if (wb) begin
            model_mem[ab] = db;
        end
        if (wa) begin
            model_mem[aa] = da;
        end
        @(posedge clk);
        #(stim_delay);
        check_value("dout_a", dout_a, exp_a);
        check_value("dout_b", dout_b, exp_b);
    endtask

    task automatic apply_reset();
        we_a = 1'b0;
        we_b = 1'b0;
        rst  = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(stim_delay);
        rst = 1'b0;
    endtask

    // **************************************************
    // directed tests.
    // **************************************************

    task automatic test_fill_readback();
        int start;
        start = fail_count;
        for (int i = 0; i < ram_depth; i++) begin
            run_cycle(1'b1, addr_t'(i), rand_bits(ram_width), 1'b0, addr_t'(i), '0);
        end
        for (int i = 0; i < ram_depth; i++) begin
            run_cycle(1'b0, addr_t'(ram_depth - 1 - i), '0, 1'b0, addr_t'(i), '0);
        end
        for (int i = 0; i < ram_depth; i++) begin
            run_cycle(1'b0, addr_t'(i), '0, 1'b1, addr_t'(i), rand_bits(ram_width));
        end
        for (int i = 0; i < ram_depth; i++) begin
            run_cycle(1'b0, addr_t'(i), '0, 1'b0, addr_t'(ram_depth - 1 - i), '0);
        end
        report_test("fill and read back", start);
    endtask

    task automatic test_own_write();
        int    start;
        addr_t x;
        start = fail_count;
        for (int k = 0; k < 4; k++) begin
            x = addr_t'(rand_bits(addr_width));
            run_cycle(1'b1, x, rand_bits(ram_width), 1'b0, ~x, '0);
            run_cycle(1'b0, ~x, '0, 1'b1, x, rand_bits(ram_width));
        end
        report_test("write-first on the writing port", start);
    endtask

    task automatic test_cross_forward();
        int    start;
        addr_t x;
        start = fail_count;
        for (int k = 0; k < 4; k++) begin
            x = addr_t'(rand_bits(addr_width));
            run_cycle(1'b1, x, rand_bits(ram_width), 1'b0, x, '0);
            run_cycle(1'b0, x, '0, 1'b1, x, rand_bits(ram_width));
        end
        report_test("cross-port forwarding", start);
    endtask

    task automatic test_same_addr_write();
        int    start;
        addr_t x;
        word_t da;
        start = fail_count;
        for (int k = 0; k < 4; k++) begin
            x  = addr_t'(rand_bits(addr_width));
            da = rand_bits(ram_width);
            run_cycle(1'b1, x, da, 1'b1, x, rand_bits(ram_width));
            run_cycle(1'b0, x, '0, 1'b0, x, '0);
            check_value("dout_a", dout_a, da);
        end
        report_test("simultaneous same-address write", start);
    endtask

    task automatic test_diff_addr_write();
        int    start;
        addr_t xa;
        start = fail_count;
        for (int k = 0; k < 4; k++) begin
            xa = addr_t'(rand_bits(addr_width));
            run_cycle(1'b1, xa, rand_bits(ram_width), 1'b1, ~xa, rand_bits(ram_width));
            run_cycle(1'b0, ~xa, '0, 1'b0, xa, '0);
        end
        report_test("simultaneous different-address writes", start);
    endtask

    task automatic test_reset_keep();
        int start;
        start = fail_count;
        for (int k = 0; k < 4; k++) begin
            run_cycle(1'b1, addr_t'(k * 8 + 1), rand_bits(ram_width),
                      1'b1, addr_t'(k * 8 + 5), rand_bits(ram_width));
        end
        apply_reset();
        for (int k = 0; k < 4; k++) begin
            run_cycle(1'b0, addr_t'(k * 8 + 5), '0, 1'b0, addr_t'(k * 8 + 1), '0);
        end
        report_test("contents survive reset", start);
    endtask

    // **************************************************
    // run control.
    // **************************************************

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        we_a        = 1'b0;
        addr_a      = '0;
        din_a       = '0;
        we_b        = 1'b0;
        addr_b      = '0;
        din_b       = '0;
        lfsr_state  = lfsr_seed;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        apply_reset();
        test_fill_readback();
        test_own_write();
        test_cross_forward();
        test_same_addr_write();
        test_diff_addr_write();
        test_reset_keep();
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/tdp_ram_pkg.sv
design/tdp_ram_array.sv
design/collision_bypass.sv
design/tdp_ram.sv
tests/tb_tdp_ram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dual-port RAM testbench with Verilator.
# Exits non-zero if the build fails, the simulation fails, or the log
# reports a failure.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_tb
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps \
    -f sources.f \
    --top-module tb_tdp_ram \
    -Mdir "$build_dir" \
    -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

exit 0
